// File: rv_csr_pkg.sv
// ==============================
// RV32 ISA side of the CSR unit.
// Register-operand CSR forms only, no immediate forms.
// ==============================
package rv_csr_pkg;

    // Operation kinds passed from decode to execute.
    typedef enum logic [2:0] {
        op_none,
        op_csrrw,
        op_csrrs,
        op_csrrc,
        op_ecall,
        op_mret,
        op_illegal
    } csr_op_t;

    // Instruction field positions.
    localparam int opcode_lsb   = 0;
    localparam int opcode_w     = 7;
    localparam int rd_lsb       = 7;
    localparam int funct3_lsb   = 12;
    localparam int funct3_w     = 3;
    localparam int rs1_lsb      = 15;
    localparam int csr_addr_lsb = 20;
    localparam int reg_idx_w    = 5;
    localparam int csr_addr_w   = 12;

    // SYSTEM opcode and its funct3 codes.
    localparam logic [opcode_w-1:0] opcode_system = 7'b111_0011;
    localparam logic [funct3_w-1:0] funct3_csrrw  = 3'b001;
    localparam logic [funct3_w-1:0] funct3_csrrs  = 3'b010;
    localparam logic [funct3_w-1:0] funct3_csrrc  = 3'b011;

    // Whole-word encodings, matched exactly.
    localparam logic [31:0] insn_ecall = 32'h0000_0073;
    localparam logic [31:0] insn_mret  = 32'h3020_0073;

    // Machine-mode CSR addresses.
    localparam logic [csr_addr_w-1:0] csr_mstatus    = 12'h300;
    localparam logic [csr_addr_w-1:0] csr_misa       = 12'h301;
    localparam logic [csr_addr_w-1:0] csr_medeleg    = 12'h302;
    localparam logic [csr_addr_w-1:0] csr_mideleg    = 12'h303;
    localparam logic [csr_addr_w-1:0] csr_mie        = 12'h304;
    localparam logic [csr_addr_w-1:0] csr_mtvec      = 12'h305;
    localparam logic [csr_addr_w-1:0] csr_mstatush   = 12'h310;
    localparam logic [csr_addr_w-1:0] csr_mscratch   = 12'h340;
    localparam logic [csr_addr_w-1:0] csr_mepc       = 12'h341;
    localparam logic [csr_addr_w-1:0] csr_mcause     = 12'h342;
    localparam logic [csr_addr_w-1:0] csr_mtval      = 12'h343;
    localparam logic [csr_addr_w-1:0] csr_mip        = 12'h344;
    localparam logic [csr_addr_w-1:0] csr_mvendorid  = 12'hf11;
    localparam logic [csr_addr_w-1:0] csr_marchid    = 12'hf12;
    localparam logic [csr_addr_w-1:0] csr_mimpid     = 12'hf13;
    localparam logic [csr_addr_w-1:0] csr_mhartid    = 12'hf14;
    localparam logic [csr_addr_w-1:0] csr_mconfigptr = 12'hf15;

    // Register fields and constants.
    localparam int          mstatus_mie_bit  = 3;
    localparam int          mstatus_mpie_bit = 7;
    localparam logic [31:0] misa_value       = 32'h4000_1100;

endpackage

// File: trap_pkg.sv
// ==============================
// Trap side of the CSR unit.
// Only lines 16 to 31 exist as interrupts.
// ==============================
package trap_pkg;

    // Data path width.
    localparam int xlen = 32;
    typedef logic [xlen-1:0] word_t;

    // Cause code width, enough for 0 to 31.
    localparam int cause_w = 5;

    // Synchronous trap causes.
    localparam logic [cause_w-1:0] cause_illegal = 5'd2;
    localparam logic [cause_w-1:0] cause_ecall_m = 5'd11;

    // Interrupt flag in mcause.
    localparam int mcause_int_bit = 31;

    // External interrupt line range.
    localparam int irq_lo = 16;
    localparam int irq_hi = 31;

endpackage

// File: csr_pipe_if.sv
// ==============================
// Stage links of the CSR unit.
// valid is a one-cycle strobe, fields count only while it is high.
// ==============================

// Decoded operation, decode to execute.
interface csr_op_if;
    logic                                 valid;
    rv_csr_pkg::csr_op_t                  op;
    logic [rv_csr_pkg::csr_addr_w-1:0]    csr_addr;
    trap_pkg::word_t                      wdata;
    // rs1 field was x0.
    logic                                 rs1_zero;
    logic [rv_csr_pkg::reg_idx_w-1:0]     rd;
    trap_pkg::word_t                      pc;

    modport decode (output valid, op, csr_addr, wdata, rs1_zero, rd, pc);
    modport execute(input  valid, op, csr_addr, wdata, rs1_zero, rd, pc);
endinterface

// Executed result, execute to result.
interface csr_res_if;
    logic                                 valid;
    logic [rv_csr_pkg::reg_idx_w-1:0]     rd;
    trap_pkg::word_t                      rd_val;
    logic                                 rd_we;
    // Fetch redirect and its target.
    logic                                 redirect;
    trap_pkg::word_t                      target;

    modport execute(output valid, rd, rd_val, rd_we, redirect, target);
    modport result (input  valid, rd, rd_val, rd_we, redirect, target);
endinterface

// File: csr_decode.sv
// ==============================
// Decode stage, one cycle.
// All legality checks are made here.
// ==============================
module csr_decode (
    input  logic            clk,
    input  logic            rst,
    input  logic [31:0]     insn,
    input  trap_pkg::word_t rs1_val,
    input  trap_pkg::word_t pc,
    input  logic            valid,
    csr_op_if.decode        op_out
);

    logic [rv_csr_pkg::opcode_w-1:0]   opcode;
    logic [rv_csr_pkg::funct3_w-1:0]   funct3;
    logic [rv_csr_pkg::reg_idx_w-1:0]  rs1_idx;
    logic [rv_csr_pkg::reg_idx_w-1:0]  rd_idx;
    logic [rv_csr_pkg::csr_addr_w-1:0] addr;
    logic                              exists;
    logic                              rdonly;
    rv_csr_pkg::csr_op_t               op_next;

    // Instruction fields.
    assign opcode  = insn[rv_csr_pkg::opcode_lsb +: rv_csr_pkg::opcode_w];
    assign funct3  = insn[rv_csr_pkg::funct3_lsb +: rv_csr_pkg::funct3_w];
    assign rs1_idx = insn[rv_csr_pkg::rs1_lsb +: rv_csr_pkg::reg_idx_w];
    assign rd_idx  = insn[rv_csr_pkg::rd_lsb +: rv_csr_pkg::reg_idx_w];
    assign addr    = insn[rv_csr_pkg::csr_addr_lsb +: rv_csr_pkg::csr_addr_w];

    // CSR map, writable ones first.
    always_comb begin
        exists = 1'b1;
        rdonly = 1'b1;
        case (addr)
            rv_csr_pkg::csr_mstatus, rv_csr_pkg::csr_mie, rv_csr_pkg::csr_mtvec,
            rv_csr_pkg::csr_mscratch, rv_csr_pkg::csr_mepc, rv_csr_pkg::csr_mcause:
                rdonly = 1'b0;
            rv_csr_pkg::csr_misa, rv_csr_pkg::csr_medeleg, rv_csr_pkg::csr_mideleg,
            rv_csr_pkg::csr_mstatush, rv_csr_pkg::csr_mip, rv_csr_pkg::csr_mtval,
            rv_csr_pkg::csr_mvendorid, rv_csr_pkg::csr_marchid, rv_csr_pkg::csr_mimpid,
            rv_csr_pkg::csr_mhartid, rv_csr_pkg::csr_mconfigptr:
                rdonly = 1'b1;
            default:
                exists = 1'b0;
        endcase
    end

    // Opcode selection.
    always_comb begin
        op_next = rv_csr_pkg::op_illegal;
        if (!valid) begin
            op_next = rv_csr_pkg::op_none;
        end else if (insn == rv_csr_pkg::insn_ecall) begin
            op_next = rv_csr_pkg::op_ecall;
        end else if (insn == rv_csr_pkg::insn_mret) begin
            op_next = rv_csr_pkg::op_mret;
        end else if (opcode == rv_csr_pkg::opcode_system) begin
            case (funct3)
                rv_csr_pkg::funct3_csrrw: op_next = rv_csr_pkg::op_csrrw;
                rv_csr_pkg::funct3_csrrs: op_next = rv_csr_pkg::op_csrrs;
                rv_csr_pkg::funct3_csrrc: op_next = rv_csr_pkg::op_csrrc;
                default:                  op_next = rv_csr_pkg::op_illegal;
            endcase
            // Missing CSR, or a write that hits a read-only one.
            if (op_next != rv_csr_pkg::op_illegal && (!exists || (rdonly &&
                    (op_next == rv_csr_pkg::op_csrrw || rs1_idx != '0)))) begin
                op_next = rv_csr_pkg::op_illegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_out.valid <= 1'b0;
        end else begin
            op_out.valid <= valid;
        end
    end

    // Operation fields.
    always_ff @(posedge clk) begin
        op_out.op       <= op_next;
        op_out.csr_addr <= addr;
        op_out.wdata    <= rs1_val;
        op_out.rs1_zero <= (rs1_idx == '0);
        op_out.rd       <= rd_idx;
        op_out.pc       <= pc;
    end

endmodule

// File: irq_priority.sv
// ==============================
// Interrupt selection, combinational.
// Lowest pending line wins; mstatus.MIE is applied by execute.
// ==============================
module irq_priority (
    input  logic [trap_pkg::irq_hi:trap_pkg::irq_lo] pending,
    input  trap_pkg::word_t                          mie,
    output logic                                     irq_take,
    output logic [trap_pkg::cause_w-1:0]             irq_cause
);

    logic [trap_pkg::irq_hi:trap_pkg::irq_lo] masked;

    // Only enabled lines compete.
    assign masked   = pending & mie[trap_pkg::irq_hi:trap_pkg::irq_lo];
    assign irq_take = |masked;

    // Walk downward so the lowest set line is left.
    always_comb begin
        irq_cause = '0;
        for (int i = trap_pkg::irq_hi; i >= trap_pkg::irq_lo; i--) begin
            if (masked[i]) begin
                irq_cause = trap_pkg::cause_w'(i);
            end
        end
    end

endmodule

// File: csr_execute.sv
// ==============================
// Execute stage, one cycle, holds the CSRs.
// Legality comes from decode and is trusted.
// ==============================
module csr_execute #(
    parameter trap_pkg::word_t hartid = '0
) (
    input  logic                                     clk,
    input  logic                                     rst,
    csr_op_if.execute                                op_in,
    input  logic                                     irq_take,
    input  logic [trap_pkg::cause_w-1:0]             irq_cause,
    input  logic [trap_pkg::irq_hi:trap_pkg::irq_lo] irq_pending,
    output trap_pkg::word_t                          mie,
    csr_res_if.execute                               res_out
);

    // CSR storage.
    logic                          mstatus_mie;
    logic                          mstatus_mpie;
    logic [31:2]                   mtvec;
    trap_pkg::word_t               mscratch;
    logic [31:1]                   mepc;
    logic                          mcause_int;
    logic [trap_pkg::cause_w-1:0]  mcause_no;

    trap_pkg::word_t               rdata;
    trap_pkg::word_t               wval;
    logic                          is_csr;
    logic                          take_irq;
    logic                          trap;
    logic                          do_mret;
    logic                          do_write;
    logic [trap_pkg::cause_w-1:0]  cause;

    // Read mux.
    always_comb begin
        rdata = '0;
        case (op_in.csr_addr)
            rv_csr_pkg::csr_mstatus: begin
                rdata[rv_csr_pkg::mstatus_mie_bit]  = mstatus_mie;
                rdata[rv_csr_pkg::mstatus_mpie_bit] = mstatus_mpie;
            end
            rv_csr_pkg::csr_misa:     rdata = rv_csr_pkg::misa_value;
            rv_csr_pkg::csr_mie:      rdata = mie;
            rv_csr_pkg::csr_mtvec:    rdata = {mtvec, 2'b00};
            rv_csr_pkg::csr_mip:      rdata[trap_pkg::irq_hi:trap_pkg::irq_lo] = irq_pending;
            rv_csr_pkg::csr_mscratch: rdata = mscratch;
            rv_csr_pkg::csr_mepc:     rdata = {mepc, 1'b0};
            rv_csr_pkg::csr_mcause: begin
                rdata[trap_pkg::mcause_int_bit]  = mcause_int;
                rdata[trap_pkg::cause_w-1:0]     = mcause_no;
            end
            rv_csr_pkg::csr_mhartid:  rdata = hartid;
            // Remaining ones read as zero.
            default:                  rdata = '0;
        endcase
    end

    // Read-modify-write value.
    always_comb begin
        case (op_in.op)
            rv_csr_pkg::op_csrrs: wval = rdata | op_in.wdata;
            rv_csr_pkg::op_csrrc: wval = rdata & ~op_in.wdata;
            default:              wval = op_in.wdata;
        endcase
    end

    // Priority: interrupt, ECALL or illegal, MRET, CSR access.
    assign take_irq = op_in.valid && irq_take && mstatus_mie;
    assign trap     = take_irq || (op_in.valid && (op_in.op == rv_csr_pkg::op_ecall ||
                                                   op_in.op == rv_csr_pkg::op_illegal));
    assign do_mret  = op_in.valid && !trap && op_in.op == rv_csr_pkg::op_mret;
    assign is_csr   = op_in.op == rv_csr_pkg::op_csrrw || op_in.op == rv_csr_pkg::op_csrrs ||
                      op_in.op == rv_csr_pkg::op_csrrc;
    // Set and clear with x0 only read.
    assign do_write = op_in.valid && !trap && is_csr &&
                      (op_in.op == rv_csr_pkg::op_csrrw || !op_in.rs1_zero);
    assign cause    = take_irq ? irq_cause :
                      (op_in.op == rv_csr_pkg::op_ecall) ? trap_pkg::cause_ecall_m :
                      trap_pkg::cause_illegal;

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie      <= 1'b0;
            mstatus_mpie     <= 1'b0;
            mie              <= '0;
            mtvec            <= '0;
            mscratch         <= '0;
            mepc             <= '0;
            mcause_int       <= 1'b0;
            mcause_no        <= '0;
            res_out.valid    <= 1'b0;
            res_out.rd_we    <= 1'b0;
            res_out.redirect <= 1'b0;
        end else begin
            res_out.valid    <= op_in.valid;
            res_out.rd_we    <= op_in.valid && !trap && is_csr;
            res_out.redirect <= trap || do_mret;
            if (trap) begin
                // Trap entry.
                mepc         <= op_in.pc[31:1];
                mcause_int   <= take_irq;
                mcause_no    <= cause;
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
            end else if (do_mret) begin
                mstatus_mie  <= mstatus_mpie;
            end else if (do_write) begin
                case (op_in.csr_addr)
                    rv_csr_pkg::csr_mstatus: begin
                        mstatus_mie  <= wval[rv_csr_pkg::mstatus_mie_bit];
                        mstatus_mpie <= wval[rv_csr_pkg::mstatus_mpie_bit];
                    end
                    rv_csr_pkg::csr_mie:      mie      <= wval;
                    rv_csr_pkg::csr_mtvec:    mtvec    <= wval[31:2];
                    rv_csr_pkg::csr_mscratch: mscratch <= wval;
                    rv_csr_pkg::csr_mepc:     mepc     <= wval[31:1];
                    rv_csr_pkg::csr_mcause: begin
                        mcause_int <= wval[trap_pkg::mcause_int_bit];
                        mcause_no  <= wval[trap_pkg::cause_w-1:0];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Result payload, old CSR value to rd.
    always_ff @(posedge clk) begin
        res_out.rd     <= op_in.rd;
        res_out.rd_val <= rdata;
        res_out.target <= trap ? {mtvec, 2'b00} : {mepc, 1'b0};
    end

endmodule

// File: csr_result.sv
// ==============================
// Result stage, one cycle.
// No rd write to x0 or on a redirect.
// ==============================
module csr_result (
    input  logic                               clk,
    input  logic                               rst,
    csr_res_if.result                          res_in,
    output logic                               out_valid,
    output logic                               out_rd_we,
    output logic [rv_csr_pkg::reg_idx_w-1:0]   out_rd,
    output trap_pkg::word_t                    out_rd_val,
    output logic                               out_redirect,
    output trap_pkg::word_t                    out_target
);

    // Strobes, low on idle cycles.
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid    <= 1'b0;
            out_rd_we    <= 1'b0;
            out_redirect <= 1'b0;
        end else begin
            out_valid    <= res_in.valid;
            out_rd_we    <= res_in.valid && res_in.rd_we && !res_in.redirect &&
                            res_in.rd != '0;
            out_redirect <= res_in.valid && res_in.redirect;
        end
    end

    // Payload.
    always_ff @(posedge clk) begin
        out_rd     <= res_in.rd;
        out_rd_val <= res_in.rd_val;
        out_target <= res_in.target;
    end

endmodule

// File: csr_unit_top.sv
// ==============================
// CSR and trap unit, three-stage pipeline.
// Result 3 cycles after in_valid, no back-pressure.
// ==============================
module csr_unit_top #(
    parameter trap_pkg::word_t hartid = '0
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     in_valid,
    input  logic [31:0]                              in_insn,
    input  trap_pkg::word_t                          in_rs1_val,
    input  trap_pkg::word_t                          in_pc,
    input  logic [trap_pkg::irq_hi:trap_pkg::irq_lo] irq,
    output logic                                     out_valid,
    output logic                                     out_rd_we,
    output logic [rv_csr_pkg::reg_idx_w-1:0]         out_rd,
    output trap_pkg::word_t                          out_rd_val,
    output logic                                     out_redirect,
    output trap_pkg::word_t                          out_target
);

    logic [trap_pkg::irq_hi:trap_pkg::irq_lo] irq_pending;
    trap_pkg::word_t                          mie;
    logic                                     irq_take;
    logic [trap_pkg::cause_w-1:0]             irq_cause;

    csr_op_if  op_link ();
    csr_res_if res_link ();

    // Sampled with the instruction, seen in execute.
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_pending <= '0;
        end else begin
            irq_pending <= irq;
        end
    end

    csr_decode u_decode (
        .clk     (clk),
        .rst     (rst),
        .insn    (in_insn),
        .rs1_val (in_rs1_val),
        .pc      (in_pc),
        .valid   (in_valid),
        .op_out  (op_link.decode)
    );

    irq_priority u_irq (
        .pending   (irq_pending),
        .mie       (mie),
        .irq_take  (irq_take),
        .irq_cause (irq_cause)
    );

    csr_execute #(.hartid(hartid)) u_execute (
        .clk         (clk),
        .rst         (rst),
        .op_in       (op_link.execute),
        .irq_take    (irq_take),
        .irq_cause   (irq_cause),
        .irq_pending (irq_pending),
        .mie         (mie),
        .res_out     (res_link.execute)
    );

    csr_result u_result (
        .clk          (clk),
        .rst          (rst),
        .res_in       (res_link.result),
        .out_valid    (out_valid),
        .out_rd_we    (out_rd_we),
        .out_rd       (out_rd),
        .out_rd_val   (out_rd_val),
        .out_redirect (out_redirect),
        .out_target   (out_target)
    );

endmodule

// File: tb_csr_unit.sv
// ==============================
// Self-checking testbench for csr_unit_top.
// Reads ten words per vector from csr_unit_testdata.txt, run from the project root.
// Results must come in order and 3 cycles after issue.
// ==============================
module tb_csr_unit;

    // Ten hex words per vector.
    localparam int words      = 10;
    localparam int max_vecs   = 64;
    localparam int clk_period = 8;

    logic         clk;
    logic         rst;
    logic         in_valid;
    logic [31:0]  in_insn;
    logic [31:0]  in_rs1_val;
    logic [31:0]  in_pc;
    logic [31:16] irq;
    logic         out_valid;
    logic         out_rd_we;
    logic [4:0]   out_rd;
    logic [31:0]  out_rd_val;
    logic         out_redirect;
    logic [31:0]  out_target;

    logic [31:0]  vec_mem [0:words*max_vecs-1];
    int           num_vecs;
    int           vi;
    int           base;
    int           cycle;
    int           limit;
    integer       seed;
    // Vectors in flight and the cycle each result is due.
    int           exp_idx [$];
    int           exp_due [$];

    csr_unit_top DUT (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_insn      (in_insn),
        .in_rs1_val   (in_rs1_val),
        .in_pc        (in_pc),
        .irq          (irq),
        .out_valid    (out_valid),
        .out_rd_we    (out_rd_we),
        .out_rd       (out_rd),
        .out_rd_val   (out_rd_val),
        .out_redirect (out_redirect),
        .out_target   (out_target)
    );

    always #(clk_period / 2) clk = ~clk;

    // Free-running cycle count.
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic string test_name(input logic [31:0] num);
        case (num)
            1:       test_name = "csr_access";
            2:       test_name = "read_only";
            3:       test_name = "ecall_mret";
            4:       test_name = "irq_priority";
            5:       test_name = "write_masks";
            6:       test_name = "back_to_back";
            default: test_name = "unknown";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_result(input int idx);
        int    b;
        string name;
        b    = idx * words;
        name = $sformatf("%s vector %0d", test_name(vec_mem[b+9]), idx + 1);
        check_value({name, " rd_we"}, vec_mem[b+4], out_rd_we);
        check_value({name, " redirect"}, vec_mem[b+7], out_redirect);
        // Payload only counts where a strobe says so.
        if (vec_mem[b+4][0]) begin
            check_value({name, " rd"}, vec_mem[b+5], out_rd);
            check_value({name, " rd_val"}, vec_mem[b+6], out_rd_val);
        end
        if (vec_mem[b+7][0]) begin
            check_value({name, " target"}, vec_mem[b+8], out_target);
        end
    endtask

    // Outputs are sampled mid-cycle.
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            if (exp_idx.size() == 0) begin
                stop_run($sformatf("out_valid high at cycle %0d with nothing in flight", cycle));
            end else if (exp_due[0] != cycle) begin
                stop_run($sformatf("out_valid at cycle %0d, result was due at cycle %0d",
                                   cycle, exp_due[0]));
            end else begin
                compare_result(exp_idx.pop_front());
                void'(exp_due.pop_front());
            end
        end else if (exp_due.size() != 0 && exp_due[0] <= cycle) begin
            stop_run($sformatf("no out_valid for vector %0d at cycle %0d",
                               exp_idx[0] + 1, exp_due[0]));
        end
    end

    // Timeout.
    always @(negedge clk) begin
        if (cycle > limit) begin
            stop_run($sformatf("timeout after %0d cycles, %0d results missing",
                               limit, exp_idx.size()));
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_insn    = '0;
        in_rs1_val = '0;
        in_pc      = '0;
        irq        = '0;
        cycle      = 0;
        seed       = 32'hd45d_9749;
        // Test number 0 marks a slot the data file left empty.
        for (vi = 0; vi < max_vecs; vi++) begin
            vec_mem[vi * words + 9] = '0;
        end
        $readmemh("csr_unit_testdata.txt", vec_mem);
        num_vecs = 0;
        while (num_vecs < max_vecs && vec_mem[num_vecs * words + 9] != 0) begin
            num_vecs++;
        end
        limit = 2 * num_vecs + 40;
        if (num_vecs == 0) begin
            stop_run("no test vectors read from csr_unit_testdata.txt");
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (vi = 0; vi < num_vecs; vi++) begin
            base = vi * words;
            // Occasional idle cycle outside the back-to-back group.
            if (vec_mem[base+9] != 6 && ($random(seed) & 3) == 0) begin
                @(posedge clk);
                in_valid <= 1'b0;
                irq      <= '0;
            end
            @(posedge clk);
            in_valid   <= 1'b1;
            in_insn    <= vec_mem[base];
            in_rs1_val <= vec_mem[base+1];
            in_pc      <= vec_mem[base+2];
            irq        <= vec_mem[base+3][31:16];
            exp_idx.push_back(vi);
            // DUT samples at the next edge and answers 3 edges later.
            exp_due.push_back(cycle + 4);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        irq      <= '0;
        while (exp_idx.size() != 0) begin
            @(negedge clk);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: csr_unit_testdata.txt
// insn rs1_val pc irq(lines 31:16 in place) | rd_we rd rd_val redirect target test
// Tests: 1 access, 2 read-only, 3 ecall/mret, 4 irq, 5 masks, 6 back-to-back.
340022F3 00000000 00000100 00000000 1 05 00000000 0 00000000 1
305022F3 00000000 00000104 00000000 1 05 00000000 0 00000000 1
304022F3 00000000 00000108 00000000 1 05 00000000 0 00000000 1
340312F3 12345678 0000010C 00000000 1 05 00000000 0 00000000 1
340322F3 000000F0 00000110 00000000 1 05 12345678 0 00000000 1
340332F3 00000078 00000114 00000000 1 05 123456F8 0 00000000 1
340022F3 FFFFFFFF 00000118 00000000 1 05 12345680 0 00000000 1
340022F3 00000000 0000011C 00000000 1 05 12345680 0 00000000 1
F14022F3 00000000 00000120 00000000 1 05 00000000 0 00000000 2
301022F3 00000000 00000124 00000000 1 05 40001100 0 00000000 2
F11022F3 00000000 00000128 00000000 1 05 00000000 0 00000000 2
305312F3 00000200 0000012C 00000000 1 05 00000000 0 00000000 2
F14312F3 00000001 00000130 00000000 0 00 00000000 1 00000200 2
342022F3 00000000 00000134 00000000 1 05 00000002 0 00000000 2
341022F3 00000000 00000138 00000000 1 05 00000130 0 00000000 2
7C0022F3 00000000 0000013C 00000000 0 00 00000000 1 00000200 2
341022F3 00000000 00000140 00000000 1 05 0000013C 0 00000000 2
305312F3 00000400 00000144 00000000 1 05 00000200 0 00000000 3
300322F3 00000008 00000148 00000000 1 05 00000000 0 00000000 3
00000073 00000000 0000014C 00000000 0 00 00000000 1 00000400 3
342022F3 00000000 00000150 00000000 1 05 0000000B 0 00000000 3
300022F3 00000000 00000154 00000000 1 05 00000080 0 00000000 3
30200073 00000000 00000158 00000000 0 00 00000000 1 0000014C 3
300022F3 00000000 0000015C 00000000 1 05 00000088 0 00000000 3
304312F3 00120000 00000160 00000000 1 05 00000000 0 00000000 4
300322F3 00000008 00000164 00000000 1 05 00000088 0 00000000 4
340022F3 00000000 00000168 00120000 0 00 00000000 1 00000400 4
342022F3 00000000 0000016C 00000000 1 05 80000011 0 00000000 4
300022F3 00000000 00000170 00000000 1 05 00000080 0 00000000 4
340022F3 00000000 00000174 00120000 1 05 12345680 0 00000000 4
305312F3 FFFFFFFF 00000178 00000000 1 05 00000400 0 00000000 5
305022F3 00000000 0000017C 00000000 1 05 FFFFFFFC 0 00000000 5
341312F3 FFFFFFFF 00000180 00000000 1 05 00000168 0 00000000 5
341022F3 00000000 00000184 00000000 1 05 FFFFFFFE 0 00000000 5
342312F3 FFFFFFFF 00000188 00000000 1 05 80000011 0 00000000 5
342022F3 00000000 0000018C 00000000 1 05 8000001F 0 00000000 5
340312F3 A5A5A5A5 00000190 00000000 1 05 12345680 0 00000000 6
340322F3 0000000F 00000194 00000000 1 05 A5A5A5A5 0 00000000 6
340332F3 A0000000 00000198 00000000 1 05 A5A5A5AF 0 00000000 6
34031073 11111111 0000019C 00000000 0 00 00000000 0 00000000 6
340022F3 00000000 000001A0 00000000 1 05 11111111 0 00000000 6

// File: flist.f
rv_csr_pkg.sv
trap_pkg.sv
csr_pipe_if.sv
csr_decode.sv
irq_priority.sv
csr_execute.sv
csr_result.sv
csr_unit_top.sv
tb_csr_unit.sv
